// File: source/video_pkg.sv
package video_pkg;

    // ********************
    // Stream geometry
    // ********************

    localparam int unsigned PIXEL_WIDTH = 10; // One colour channel
    localparam int unsigned POS_WIDTH   = 12; // Up to 4096 x 4096 pixels

    // ********************
    // Stream types
    // ********************

    typedef struct packed {
        logic [PIXEL_WIDTH-1:0] red;
        logic [PIXEL_WIDTH-1:0] green;
        logic [PIXEL_WIDTH-1:0] blue;
    } pixel_t;

    // One pixel per clock while line_valid is high, no handshake
    typedef struct packed {
        pixel_t pixel;
        logic   line_valid;
        logic   frame_valid;
    } video_bus_t;

    typedef struct packed {
        logic [POS_WIDTH-1:0] x; // Column within the line
        logic [POS_WIDTH-1:0] y; // Row within the frame
    } pos_t;

endpackage

// File: source/csr_pkg.sv
package csr_pkg;

    // ********************
    // APB bus
    // ********************

    localparam int unsigned APB_ADDR_WIDTH = 4;
    localparam int unsigned APB_DATA_WIDTH = 32;

    typedef struct packed {
        logic                      psel;
        logic                      penable;
        logic                      pwrite;
        logic [APB_ADDR_WIDTH-1:0] paddr;
        logic [APB_DATA_WIDTH-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_WIDTH-1:0] prdata;
        logic                      pready;
        logic                      pslverr;
    } apb_rsp_t;

    // ********************
    // Register map
    // ********************

    localparam logic [APB_ADDR_WIDTH-1:0] CTRL_ADDR     = 4'h0;
    localparam logic [APB_ADDR_WIDTH-1:0] X_WINDOW_ADDR = 4'h4;
    localparam logic [APB_ADDR_WIDTH-1:0] Y_WINDOW_ADDR = 4'h8;
    localparam logic [APB_ADDR_WIDTH-1:0] STATUS_ADDR   = 4'hC; // Read only

    localparam int unsigned CTRL_ENABLE_BIT = 0;
    // Window and status words share one layout: low field and high field
    localparam int unsigned FIELD_WIDTH     = video_pkg::POS_WIDTH;
    localparam int unsigned WIN_START_LSB   = 0;
    localparam int unsigned WIN_END_LSB     = 16;

    typedef struct packed {
        logic                   enable;
        logic [FIELD_WIDTH-1:0] x_start;
        logic [FIELD_WIDTH-1:0] x_end;   // Exclusive
        logic [FIELD_WIDTH-1:0] y_start;
        logic [FIELD_WIDTH-1:0] y_end;   // Exclusive
    } crop_cfg_t;

    typedef struct packed {
        logic [FIELD_WIDTH-1:0] line_count;
        logic [FIELD_WIDTH-1:0] last_width;
    } crop_stats_t;

endpackage

// File: source/crop_csr.sv
`timescale 1ns/1ps

module crop_csr (
    input  logic                 pixel_clock_in,
    input  logic                 rst,
    input  csr_pkg::apb_req_t    apb_req,
    output csr_pkg::apb_rsp_t    apb_rsp,
    output csr_pkg::crop_cfg_t   crop_cfg,
    input  csr_pkg::crop_stats_t crop_stats
);

    import csr_pkg::*;

    crop_cfg_t                 cfg_q;
    logic                      access;
    logic                      addr_valid;
    logic                      write_error;
    logic [APB_DATA_WIDTH-1:0] read_data;

    assign access = apb_req.psel && apb_req.penable; // Access phase

    // ********************
    // Address decode and read mux
    // ********************

    always_comb begin
        addr_valid = 1'b1;
        read_data  = '0;
        case (apb_req.paddr)
            CTRL_ADDR: begin
                read_data[CTRL_ENABLE_BIT] = cfg_q.enable;
            end
            X_WINDOW_ADDR: begin
                read_data[WIN_START_LSB +: FIELD_WIDTH] = cfg_q.x_start;
                read_data[WIN_END_LSB +: FIELD_WIDTH]   = cfg_q.x_end;
            end
            Y_WINDOW_ADDR: begin
                read_data[WIN_START_LSB +: FIELD_WIDTH] = cfg_q.y_start;
                read_data[WIN_END_LSB +: FIELD_WIDTH]   = cfg_q.y_end;
            end
            STATUS_ADDR: begin
                read_data[WIN_START_LSB +: FIELD_WIDTH] = crop_stats.line_count;
                read_data[WIN_END_LSB +: FIELD_WIDTH]   = crop_stats.last_width;
            end
            default: begin
                addr_valid = 1'b0;
            end
        endcase
    end

    assign write_error = apb_req.pwrite && (apb_req.paddr == STATUS_ADDR);

    // No wait states, so every access phase completes at once
    assign apb_rsp.pready  = access;
    assign apb_rsp.pslverr = access && (!addr_valid || write_error);
    assign apb_rsp.prdata  = (access && !apb_req.pwrite) ? read_data : '0;

    // ********************
    // Register writes
    // ********************

    always_ff @(posedge pixel_clock_in) begin
        if (rst) begin
            cfg_q <= '0;
        end else if (access && apb_req.pwrite && addr_valid && !write_error) begin
            case (apb_req.paddr)
                CTRL_ADDR: begin
                    cfg_q.enable <= apb_req.pwdata[CTRL_ENABLE_BIT];
                end
                X_WINDOW_ADDR: begin
                    cfg_q.x_start <= apb_req.pwdata[WIN_START_LSB +: FIELD_WIDTH];
                    cfg_q.x_end   <= apb_req.pwdata[WIN_END_LSB +: FIELD_WIDTH];
                end
                Y_WINDOW_ADDR: begin
                    cfg_q.y_start <= apb_req.pwdata[WIN_START_LSB +: FIELD_WIDTH];
                    cfg_q.y_end   <= apb_req.pwdata[WIN_END_LSB +: FIELD_WIDTH];
                end
                default: begin
                end
            endcase
        end
    end

    assign crop_cfg = cfg_q; // The window only takes effect at the next frame start

endmodule

// File: source/raster_counter.sv
`timescale 1ns/1ps

module raster_counter (
    input  logic                pixel_clock_in,
    input  logic                rst,
    input  video_pkg::video_bus_t video_in,
    output video_pkg::video_bus_t video,
    output video_pkg::pos_t     pos,
    output logic                frame_start
);

    import video_pkg::*;

    pixel_t               pixel_q;
    logic                 line_valid_prev;
    logic                 frame_valid_prev;
    logic [POS_WIDTH-1:0] x_count; // Column of the next incoming pixel
    logic [POS_WIDTH-1:0] y_count; // Row of the current line
    pos_t                 pos_q;
    logic                 frame_start_q;

    always_ff @(posedge pixel_clock_in) begin
        pixel_q <= video_in.pixel;
    end

    always_ff @(posedge pixel_clock_in) begin
        if (rst) begin
            line_valid_prev  <= 1'b0;
            frame_valid_prev <= 1'b0;
            frame_start_q    <= 1'b0;
            x_count          <= '0;
            y_count          <= '0;
            pos_q            <= '0;
        end else begin
            line_valid_prev  <= video_in.line_valid;
            frame_valid_prev <= video_in.frame_valid;
            frame_start_q    <= video_in.frame_valid && !frame_valid_prev;

            if (!video_in.frame_valid) begin
                // Blanking between frames
                x_count <= '0;
                y_count <= '0;
                pos_q   <= '0;
            end else begin
                pos_q <= '{x: x_count, y: y_count};
                if (video_in.line_valid) begin
                    x_count <= x_count + 1'b1;
                end else begin
                    x_count <= '0;
                    if (line_valid_prev) begin
                        y_count <= y_count + 1'b1; // Line just ended
                    end
                end
            end
        end
    end

    assign video = '{
        pixel:       pixel_q,
        line_valid:  line_valid_prev,
        frame_valid: frame_valid_prev
    };
    assign pos         = pos_q;
    assign frame_start = frame_start_q;

endmodule

// File: source/crop_window.sv
`timescale 1ns/1ps

module crop_window (
    input  logic                  pixel_clock_in,
    input  logic                  rst,
    input  csr_pkg::crop_cfg_t    crop_cfg,
    input  video_pkg::video_bus_t video,
    input  video_pkg::pos_t       pos,
    input  logic                  frame_start,
    output video_pkg::video_bus_t video_tagged,
    output logic                  keep
);

    import video_pkg::*;
    import csr_pkg::*;

    crop_cfg_t shadow;
    crop_cfg_t active;
    logic      x_inside;
    logic      y_inside;
    logic      keep_next;
    pixel_t    pixel_q;
    logic      line_valid_q;
    logic      frame_valid_q;
    logic      keep_q;

    // ********************
    // Window test
    // ********************

    // The first pixel of a frame can arrive together with frame_start
    assign active = frame_start ? crop_cfg : shadow;

    // Half-open ranges, so an end at or below the start keeps nothing
    assign x_inside = (pos.x >= active.x_start) && (pos.x < active.x_end);
    assign y_inside = (pos.y >= active.y_start) && (pos.y < active.y_end);

    assign keep_next = video.line_valid && (!active.enable || (x_inside && y_inside));

    // ********************
    // Pipeline register
    // ********************

    always_ff @(posedge pixel_clock_in) begin
        pixel_q <= video.pixel;
    end

    always_ff @(posedge pixel_clock_in) begin
        if (rst) begin
            shadow        <= '0;
            line_valid_q  <= 1'b0;
            frame_valid_q <= 1'b0;
            keep_q        <= 1'b0;
        end else begin
            if (frame_start) begin
                shadow <= crop_cfg; // Held for the rest of the frame
            end
            line_valid_q  <= video.line_valid;
            frame_valid_q <= video.frame_valid;
            keep_q        <= keep_next;
        end
    end

    assign video_tagged = '{
        pixel:       pixel_q,
        line_valid:  line_valid_q,
        frame_valid: frame_valid_q
    };
    assign keep = keep_q;

endmodule

// File: source/crop_output.sv
`timescale 1ns/1ps

module crop_output (
    input  logic                  pixel_clock_in,
    input  logic                  rst,
    input  video_pkg::video_bus_t video_tagged,
    input  logic                  keep,
    output video_pkg::video_bus_t video_out,
    output csr_pkg::crop_stats_t  crop_stats
);

    import video_pkg::*;

    pixel_t               pixel_q;
    logic                 line_valid_q;
    logic                 frame_valid_q;
    logic                 frame_end;
    logic [POS_WIDTH-1:0] run_width;  // Kept pixels in the latest non-empty line
    logic [POS_WIDTH-1:0] line_count; // Non-empty lines so far in this frame
    logic [POS_WIDTH-1:0] stat_lines;
    logic [POS_WIDTH-1:0] stat_width;

    // Falling edge of the delayed frame_valid lands on this clock edge
    assign frame_end = frame_valid_q && !video_tagged.frame_valid;

    always_ff @(posedge pixel_clock_in) begin
        pixel_q <= keep ? video_tagged.pixel : '0; // Blank colour outside the window
    end

    // ********************
    // Cropped stream and statistics
    // ********************

    always_ff @(posedge pixel_clock_in) begin
        if (rst) begin
            line_valid_q  <= 1'b0;
            frame_valid_q <= 1'b0;
            run_width     <= '0;
            line_count    <= '0;
            stat_lines    <= '0;
            stat_width    <= '0;
        end else begin
            line_valid_q  <= keep;
            frame_valid_q <= video_tagged.frame_valid;

            if (frame_end) begin
                stat_lines <= line_count;
                stat_width <= run_width;
                line_count <= '0;
                run_width  <= '0;
            end else if (keep) begin
                // Kept pixels form one run per line
                if (!line_valid_q) begin
                    line_count <= line_count + 1'b1;
                    run_width  <= POS_WIDTH'(1);
                end else begin
                    run_width <= run_width + 1'b1;
                end
            end
        end
    end

    assign video_out = '{
        pixel:       pixel_q,
        line_valid:  line_valid_q,
        frame_valid: frame_valid_q
    };
    assign crop_stats = '{line_count: stat_lines, last_width: stat_width};

endmodule

// File: source/camera_crop_top.sv
`timescale 1ns/1ps

module camera_crop_top (
    input  logic                  pixel_clock_in,
    input  logic                  rst,
    input  video_pkg::video_bus_t video_in,
    output video_pkg::video_bus_t video_out,
    input  csr_pkg::apb_req_t     apb_req,
    output csr_pkg::apb_rsp_t     apb_rsp
);

    import video_pkg::*;
    import csr_pkg::*;

    crop_cfg_t   crop_cfg;
    crop_stats_t crop_stats;
    video_bus_t  video_raster;
    pos_t        pos;
    logic        frame_start;
    video_bus_t  video_tagged;
    logic        keep;

    crop_csr crop_csr_inst (
        .pixel_clock_in (pixel_clock_in),
        .rst            (rst),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp),
        .crop_cfg       (crop_cfg),
        .crop_stats     (crop_stats)
    );

    // ********************
    // Pixel pipeline, one register per stage
    // ********************

    raster_counter raster_counter_inst (
        .pixel_clock_in (pixel_clock_in),
        .rst            (rst),
        .video_in       (video_in),
        .video          (video_raster),
        .pos            (pos),
        .frame_start    (frame_start)
    );

    crop_window crop_window_inst (
        .pixel_clock_in (pixel_clock_in),
        .rst            (rst),
        .crop_cfg       (crop_cfg),
        .video          (video_raster),
        .pos            (pos),
        .frame_start    (frame_start),
        .video_tagged   (video_tagged),
        .keep           (keep)
    );

    crop_output crop_output_inst (
        .pixel_clock_in (pixel_clock_in),
        .rst            (rst),
        .video_tagged   (video_tagged),
        .keep           (keep),
        .video_out      (video_out),
        .crop_stats     (crop_stats)
    );

endmodule

// File: dv/crop_tb.sv
`timescale 1ns/1ps

module crop_tb;

    import video_pkg::*;
    import csr_pkg::*;

    localparam int FRAME_W      = 24;
    localparam int FRAME_H      = 16;
    localparam int LEAD_IN      = 2;  // Frame valid before the first line
    localparam int LINE_GAP     = 4;
    localparam int FRAME_GAP    = 10;
    localparam int FRAME_CYCLES = LEAD_IN + FRAME_H * (FRAME_W + LINE_GAP) + FRAME_GAP;
    localparam int FRAMES       = 11;
    localparam int APB_OPS      = 60; // Each transfer takes 3 cycles
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT  = (FRAMES * FRAME_CYCLES + APB_OPS * 3 + RESET_CYCLES) * 12 / 10;
    localparam logic [31:0] WINDOW_MASK = 32'h0FFF_0FFF;

    logic        pixel_clock_in = 1'b0;
    logic        rst;
    video_bus_t  video_in;
    video_bus_t  video_out;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;

    logic [15:0] lfsr_state = 16'd30713;
    crop_cfg_t   model_cfg;
    video_bus_t  exp_now;    // Expected output for the input now on video_in
    video_bus_t  exp_q[$];
    video_bus_t  exp_head;
    logic        monitor_on = 1'b0;
    int          pass_count = 0;
    int          fail_count = 0;
    int          test_fails = 0;
    int          cycle_count = 0;

    camera_crop_top camera_crop_top_inst (
        .pixel_clock_in (pixel_clock_in),
        .rst            (rst),
        .video_in       (video_in),
        .video_out      (video_out),
        .apb_req        (apb_req),
        .apb_rsp        (apb_rsp)
    );

    always #20 pixel_clock_in = ~pixel_clock_in;

    // ********************
    // Helpers
    // ********************

    function automatic logic next_random_bit();
        logic out_bit;
        out_bit    = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 16'hB400; // Galois form, maximal length
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    function automatic logic [31:0] window_word(input logic [11:0] lo, input logic [11:0] hi);
        return {4'd0, hi, 4'd0, lo};
    endfunction

    task automatic check_true(input logic ok, input string what);
        assert (ok) begin
            pass_count++;
        end else begin
            $display("FAIL at %0t ns: %s", $time, what);
            fail_count++;
        end
    endtask

    task automatic step();
        @(posedge pixel_clock_in);
        #2;
    endtask

    task automatic finish_test(input string name);
        $display("%-18s done, %0d mismatches", name, fail_count - test_fails);
        test_fails = fail_count;
    endtask

    // ********************
    // APB transfers
    // ********************

    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic slverr);
        step();
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        step();
        apb_req.penable = 1'b1;
        @(negedge pixel_clock_in);
        check_true(apb_rsp.pready === 1'b1, "pready low in access phase");
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        step();
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic slverr);
        logic [31:0] unused;
        apb_access(1'b1, addr, data, unused, slverr);
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data, output logic slverr);
        apb_access(1'b0, addr, '0, data, slverr);
    endtask

    task automatic write_window(input crop_cfg_t cfg);
        logic e0;
        logic e1;
        logic e2;
        apb_write(CTRL_ADDR, {31'd0, cfg.enable}, e0);
        apb_write(X_WINDOW_ADDR, window_word(cfg.x_start, cfg.x_end), e1);
        apb_write(Y_WINDOW_ADDR, window_word(cfg.y_start, cfg.y_end), e2);
        check_true(!(e0 || e1 || e2), "pslverr on a configuration write");
        model_cfg = cfg;
    endtask

    task automatic check_status(input int lines, input int width);
        logic [31:0] data;
        logic        err;
        apb_read(STATUS_ADDR, data, err);
        check_true(!err && data[11:0] == lines && data[27:16] == width,
                   $sformatf("STATUS %h, expected %0d lines of width %0d", data, lines, width));
    endtask

    // ********************
    // Pixel stream and model
    // ********************

    task automatic drive_cycle(input video_bus_t stim, input video_bus_t expected_out);
        step();
        video_in = stim;
        exp_now  = expected_out;
    endtask

    task automatic drive_frame(output int lines, output int width);
        crop_cfg_t   win;
        video_bus_t  stim;
        video_bus_t  blank;
        logic [31:0] bits;
        logic        hit;
        int          kept;
        win   = model_cfg; // The DUT latches its window at frame start too
        blank = '{pixel: '0, line_valid: 1'b0, frame_valid: 1'b1};
        lines = 0;
        width = 0;
        repeat (LEAD_IN) drive_cycle(blank, blank);
        for (int row = 0; row < FRAME_H; row++) begin
            kept = 0;
            for (int col = 0; col < FRAME_W; col++) begin
                bits = random_bits(30);
                stim = '{pixel: bits[29:0], line_valid: 1'b1, frame_valid: 1'b1};
                hit  = !win.enable || (col >= win.x_start && col < win.x_end &&
                                       row >= win.y_start && row < win.y_end);
                kept += hit;
                drive_cycle(stim, hit ? stim : blank);
            end
            if (kept > 0) begin
                lines++;
                width = kept;
            end
            repeat (LINE_GAP) drive_cycle(blank, blank);
        end
        repeat (FRAME_GAP) drive_cycle('0, '0);
    endtask

    task automatic random_window(output crop_cfg_t cfg);
        cfg.enable  = 1'b1;
        cfg.x_start = 12'(random_bits(5)); // 0 to 31 covers empty and oversized windows
        cfg.x_end   = 12'(random_bits(5));
        cfg.y_start = 12'(random_bits(5));
        cfg.y_end   = 12'(random_bits(5));
    endtask

    // Output lags the input by 3 clocks
    always @(negedge pixel_clock_in) begin
        if (monitor_on) begin
            exp_q.push_back(exp_now);
            if (exp_q.size() > 3) begin
                exp_head = exp_q.pop_front();
                check_true(video_out === exp_head,
                           $sformatf("video_out %h, expected %h", video_out, exp_head));
            end
        end
    end

    initial begin
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge pixel_clock_in);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

    initial begin
        crop_cfg_t   cfg;
        logic [31:0] data;
        logic [31:0] wr;
        logic        err;
        logic [3:0]  reg_map [4];
        int          lines;
        int          width;
        rst       = 1'b1;
        video_in  = '0;
        apb_req   = '0;
        exp_now   = '0;
        model_cfg = '0;
        reg_map   = '{CTRL_ADDR, X_WINDOW_ADDR, Y_WINDOW_ADDR, STATUS_ADDR};
        repeat (RESET_CYCLES) @(posedge pixel_clock_in);
        #2;
        rst        = 1'b0;
        monitor_on = 1'b1;

        check_true(!video_out.line_valid && !video_out.frame_valid && !apb_rsp.pready &&
                   !apb_rsp.pslverr, "outputs not low after reset");
        foreach (reg_map[i]) begin
            apb_read(reg_map[i], data, err);
            check_true(data === 32'd0 && !err, $sformatf("offset %h reads %h after reset",
                                                         reg_map[i], data));
        end
        finish_test("reset_state");

        wr = random_bits(32);
        apb_write(CTRL_ADDR, wr, err);
        check_true(err === 1'b0, "pslverr on a CTRL write");
        model_cfg.enable = wr[0];
        apb_read(CTRL_ADDR, data, err);
        check_true(data === (wr & 32'h1) && !err, $sformatf("CTRL reads %h", data));
        wr = random_bits(32);
        apb_write(X_WINDOW_ADDR, wr, err);
        check_true(err === 1'b0, "pslverr on an X_WINDOW write");
        {model_cfg.x_end, model_cfg.x_start} = {wr[27:16], wr[11:0]};
        apb_read(X_WINDOW_ADDR, data, err);
        check_true(data === (wr & WINDOW_MASK) && !err, $sformatf("X_WINDOW reads %h", data));
        wr = random_bits(32);
        apb_write(Y_WINDOW_ADDR, wr, err);
        check_true(err === 1'b0, "pslverr on a Y_WINDOW write");
        {model_cfg.y_end, model_cfg.y_start} = {wr[27:16], wr[11:0]};
        apb_read(Y_WINDOW_ADDR, data, err);
        check_true(data === (wr & WINDOW_MASK) && !err, $sformatf("Y_WINDOW reads %h", data));
        apb_write(4'h2, random_bits(32), err);
        check_true(err === 1'b1, "write to unmapped offset 0x2 gave no pslverr");
        apb_read(4'h6, data, err);
        check_true(err === 1'b1, "read of unmapped offset 0x6 gave no pslverr");
        apb_write(STATUS_ADDR, 32'hFFFF_FFFF, err);
        check_true(err === 1'b1, "write to STATUS gave no pslverr");
        apb_read(CTRL_ADDR, data, err);
        check_true(data === {31'd0, model_cfg.enable} && !err,
                   "CTRL changed by a rejected access");
        apb_read(X_WINDOW_ADDR, data, err);
        check_true(data === window_word(model_cfg.x_start, model_cfg.x_end) && !err,
                   "X_WINDOW changed by a rejected access");
        apb_read(Y_WINDOW_ADDR, data, err);
        check_true(data === window_word(model_cfg.y_start, model_cfg.y_end) && !err,
                   "Y_WINDOW changed by a rejected access");
        finish_test("register_access");

        cfg        = model_cfg;
        cfg.enable = 1'b0; // Window stays loaded but must be ignored
        write_window(cfg);
        drive_frame(lines, width);
        check_status(lines, width);
        finish_test("pass_through");

        for (int f = 0; f < 8; f++) begin
            if (f == 6) begin
                cfg = '{enable: 1'b1, x_start: 12'd10, x_end: 12'd10, y_start: 12'd3, y_end: 12'd9};
            end else if (f == 7) begin
                cfg = '{enable: 1'b1, x_start: 12'd0, x_end: 12'hFFF, y_start: 12'd0,
                        y_end: 12'hFFF};
            end else begin
                random_window(cfg);
            end
            write_window(cfg);
            drive_frame(lines, width);
            check_status(lines, width);
        end
        finish_test("random_windows");

        write_window('{enable: 1'b1, x_start: 12'd4, x_end: 12'd12, y_start: 12'd2, y_end: 12'd8});
        fork
            drive_frame(lines, width);
            begin
                repeat (100) step();
                write_window('{enable: 1'b1, x_start: 12'd10, x_end: 12'd20, y_start: 12'd6,
                               y_end: 12'd14});
            end
        join
        check_status(lines, width);
        drive_frame(lines, width);
        check_status(lines, width);
        finish_test("mid_frame_update");

        $display("Checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: camera_crop_top.f
source/video_pkg.sv
source/csr_pkg.sv
source/crop_csr.sv
source/raster_counter.sv
source/crop_window.sv
source/crop_output.sv
source/camera_crop_top.sv
dv/crop_tb.sv

// File: Bender.yml
package:
  name: camera_crop

sources:
  # Packages first, csr_pkg uses video_pkg
  - source/video_pkg.sv
  - source/csr_pkg.sv
  # RTL
  - source/crop_csr.sv
  - source/raster_counter.sv
  - source/crop_window.sv
  - source/crop_output.sv
  - source/camera_crop_top.sv
  # Testbench
  - target: test
    files:
      - dv/crop_tb.sv
